//--- Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - .

sources:
  - files:
      - cpu_pkg.sv
      - cpu_run_ctrl.sv
      - cpu_pc_counter.sv
      - cpu_imem.sv
      - cpu_regfile.sv
      - cpu_decode_stage.sv
      - cpu_execute_stage.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_cpu_top.sv

//--- cpu_decode_stage.sv
`timescale 1ns/1ps

module cpu_decode_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  instr_t      instr,
    input  pc_t         pc,
    input  word_t       rd1,
    input  word_t       rd2,
    input  wb_t         ex_fwd,
    input  wb_t         wb,
    output reg_addr_t   ra1,
    output reg_addr_t   ra2,
    output pc_t         next_pc,
    output logic        halt_seen,
    output dec_exe_t    dec
);

    opcode_e    op;
    reg_addr_t  r1, r2;
    logic [3:0] fn;                     // ALU function or immediate
    word_t      op_a, op_b;             // Operands after forwarding
    pc_t        pc_plus2, br_off, br_target;
    logic       is_halt, is_eq, take;
    dec_exe_t   dec_d;

    // Youngest result wins, r0 is never forwarded
    function automatic word_t fwd(input reg_addr_t ra, input word_t rf_val,
                                  input wb_t s2, input wb_t s3);
        if (ra == '0)
            return '0;
        if (s2.valid && s2.rd == ra)
            return s2.data;             // Stage 2, one cycle old
        if (s3.valid && s3.rd == ra)
            return s3.data;             // Stage 3, being written now
        return rf_val;
    endfunction

    assign op  = opcode_e'(instr[15:12]);
    assign r1  = instr[11:8];
    assign r2  = instr[7:4];
    assign fn  = instr[3:0];
    assign ra1 = r1;
    assign ra2 = r2;

    assign op_a = fwd(r1, rd1, ex_fwd, wb);
    assign op_b = fwd(r2, rd2, ex_fwd, wb);

    // Branch resolved in the fetch cycle, no delay slot
    assign pc_plus2  = pc + pc_t'(2);
    assign br_off    = {{11{fn[3]}}, fn, 1'b0};    // Sign extend, halfword units
    assign br_target = pc + br_off;
    assign is_eq     = op_a == op_b;
    assign take      = (op == OP_BEQ && is_eq) || (op == OP_BNE && !is_eq);
    assign is_halt   = op == OP_HALT;

    always_comb begin
        if (is_halt)
            next_pc = pc;               // Freeze on HALT
        else if (take)
            next_pc = br_target;
        else
            next_pc = pc_plus2;
    end

    assign halt_seen = run && is_halt;

    always_comb begin
        dec_d        = '0;
        dec_d.valid  = 1'b1;
        dec_d.rd     = r1;              // Destination is always r1
        dec_d.a      = op_a;
        dec_d.b      = op_b;
        dec_d.alu_op = ALU_ADD;
        case (op)
            OP_ALU: begin
                dec_d.wr_en  = 1'b1;
                dec_d.alu_op = alu_op_e'(fn);
            end
            OP_ADDI: begin
                dec_d.wr_en = 1'b1;
                dec_d.b     = word_t'(fn);  // Zero extended
            end
            default: dec_d.wr_en = 1'b0;    // Branches and unused opcodes
        endcase
    end

    // Stage 2 operand flop
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dec <= '0;
        else if (run && !is_halt)
            dec <= dec_d;
        else
            dec <= '0;                  // Bubble when stopped or on HALT
    end

endmodule

//--- cpu_execute_stage.sv
`timescale 1ns/1ps

module cpu_execute_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dec_exe_t    dec,
    output wb_t         ex_fwd,
    output wb_t         wb
);

    word_t alu_y;

    // ALU on the stage 2 flop
    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_y = dec.a + dec.b;
            ALU_SUB: alu_y = dec.a - dec.b;
            ALU_AND: alu_y = dec.a & dec.b;
            ALU_OR:  alu_y = dec.a | dec.b;
            ALU_XOR: alu_y = dec.a ^ dec.b;
            ALU_SLL: alu_y = dec.a << dec.b[3:0];   // Low 4 bits shift amount
            default: alu_y = '0;
        endcase
    end

    // Stage 2 result, seen by decode in the same cycle
    always_comb begin
        ex_fwd.valid = dec.valid && dec.wr_en;
        ex_fwd.rd    = dec.rd;
        ex_fwd.data  = alu_y;
    end

    // Stage 3 register drives the register file write port
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wb <= '0;
        else
            wb <= ex_fwd;               // Valid only for a writing instruction
    end

endmodule

//--- cpu_imem.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_imem import cpu_pkg::*; (
    input  logic                                clk,
    input  logic                                we,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  waddr,
    input  instr_t                              wdata,
    input  pc_t                                 raddr,
    output instr_t                              rdata
);

    localparam int IAW = $clog2(`CPU_IMEM_DEPTH);

    instr_t mem [`CPU_IMEM_DEPTH];      // Loaded by the host only

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // Fetch in the same cycle, PC byte address to word index
    assign rdata = mem[raddr[IAW:1]];

endmodule

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Core sizing
`define CPU_XLEN        16
`define CPU_NREGS       16
`define CPU_IMEM_DEPTH  64      // Instruction words

// Host port address width
`define CPU_APB_AW      12

// Host address map, byte addresses
`define CPU_ADDR_CTRL   12'h000 // Bit 0 starts the core
`define CPU_ADDR_STATUS 12'h004 // Run state
`define CPU_ADDR_PC     12'h008 // Current PC
`define CPU_ADDR_REG    12'h100 // Register n at base + 4n
`define CPU_ADDR_IMEM   12'h800 // Instruction word i at base + 4i

`endif

//--- cpu_pc_counter.sv
`timescale 1ns/1ps

module cpu_pc_counter import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic pc_clear,
    input  pc_t  next_pc,
    output pc_t  pc
);

    pc_t pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (pc_clear) begin
            pc_q <= '0;                 // Start always fetches word 0
        end else if (run) begin
            pc_q <= next_pc;            // PC+2, branch target, or hold on HALT
        end
    end

    assign pc = pc_q;

    // Fetch is halfword aligned
    a_pc_even: assert property (@(posedge clk) disable iff (rst)
        pc_q[0] == 1'b0)
        else $error("pc odd: %h", pc_q);

endmodule

//--- cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]           word_t;
    typedef logic [15:0]                    instr_t;
    typedef logic [15:0]                    pc_t;       // Byte address, steps by 2
    typedef logic [$clog2(`CPU_NREGS)-1:0]  reg_addr_t;

    // Major opcode, instr[15:12]
    typedef enum logic [3:0] {
        OP_ALU  = 4'd0,
        OP_ADDI = 4'd1,
        OP_BEQ  = 4'd2,
        OP_BNE  = 4'd3,
        OP_HALT = 4'd15
    } opcode_e;

    // ALU function, instr[3:0] of an OP_ALU word
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RUN    = 2'd1,
        ST_DRAIN  = 2'd2,
        ST_HALTED = 2'd3
    } run_state_e;

    // Stage 1 to stage 2 flop
    typedef struct packed {
        logic       valid;
        logic       wr_en;      // Writes rd at writeback
        reg_addr_t  rd;
        alu_op_e    alu_op;
        word_t      a;          // Forwarded operands
        word_t      b;
    } dec_exe_t;

    // Result of a later stage
    typedef struct packed {
        logic       valid;      // Only set for a writing instruction
        reg_addr_t  rd;
        word_t      data;
    } wb_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`CPU_APB_AW-1:0] paddr;
        word_t                  pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t  prdata;
        logic   pready;
        logic   pslverr;
    } apb_rsp_t;

endpackage

//--- cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_regfile import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_addr_t   ra1,
    input  reg_addr_t   ra2,
    input  reg_addr_t   host_raddr,
    input  wb_t         wb,
    output word_t       rd1,
    output word_t       rd2,
    output word_t       host_rdata
);

    word_t regs [`CPU_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;     // r0 writes dropped here
        end
    end

    // No write-through, decode forwards from wb itself
    assign rd1        = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2        = (ra2 == '0) ? '0 : regs[ra2];
    assign host_rdata = (host_raddr == '0) ? '0 : regs[host_raddr];

    // r0 keeps its reset value however the pipeline writes it
    a_r0_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0)
        else $error("regs[0] = %h", regs[0]);

endmodule

//--- cpu_run_ctrl.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_run_ctrl import cpu_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  apb_req_t                            apb_req,
    input  logic                                halt_seen,
    input  pc_t                                 pc,
    input  word_t                               host_rdata,
    output apb_rsp_t                            apb_rsp,
    output logic                                run,
    output logic                                pc_clear,
    output reg_addr_t                           host_raddr,
    output logic                                imem_we,
    output logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  imem_waddr,
    output instr_t                              imem_wdata,
    output logic                                running,
    output logic                                halted
);

    localparam int REG_SPAN  = 4 * `CPU_NREGS;
    localparam int IMEM_SPAN = 4 * `CPU_IMEM_DEPTH;
    localparam int RAW       = $clog2(`CPU_NREGS);
    localparam int IAW       = $clog2(`CPU_IMEM_DEPTH);

    run_state_e             state, state_nxt;
    logic                   drain_cnt;          // Second drain cycle when set
    logic                   access;             // APB access phase
    logic                   hit_ctrl, hit_status, hit_pc, hit_reg, hit_imem;
    logic                   busy;               // Core owns the instruction memory
    logic                   start_ok;
    logic [`CPU_APB_AW-1:0] reg_off, imem_off;

    assign access   = apb_req.psel && apb_req.penable;
    assign busy     = (state == ST_RUN) || (state == ST_DRAIN);
    assign reg_off  = apb_req.paddr - `CPU_ADDR_REG;
    assign imem_off = apb_req.paddr - `CPU_ADDR_IMEM;

    // Address decode, word aligned only
    always_comb begin
        hit_ctrl   = apb_req.paddr == `CPU_ADDR_CTRL;
        hit_status = apb_req.paddr == `CPU_ADDR_STATUS;
        hit_pc     = apb_req.paddr == `CPU_ADDR_PC;
        hit_reg    = (apb_req.paddr >= `CPU_ADDR_REG) && (reg_off < REG_SPAN)
                     && (apb_req.paddr[1:0] == 2'b00);
        hit_imem   = (apb_req.paddr >= `CPU_ADDR_IMEM) && (imem_off < IMEM_SPAN)
                     && (apb_req.paddr[1:0] == 2'b00);
    end

    // Start only from a stopped core
    assign start_ok = access && apb_req.pwrite && hit_ctrl && apb_req.pwdata[0]
                      && (state == ST_IDLE || state == ST_HALTED);
    assign pc_clear = start_ok;                 // PC is 0 on the edge that enters RUN

    assign host_raddr = reg_off[2 +: RAW];
    assign imem_waddr = imem_off[2 +: IAW];
    assign imem_wdata = apb_req.pwdata;
    assign imem_we    = access && apb_req.pwrite && hit_imem && !busy;

    // Read mux and error response
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;                 // No wait states
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            if (!apb_req.pwrite) begin
                if (hit_status)
                    apb_rsp.prdata = word_t'(state);
                else if (hit_pc)
                    apb_rsp.prdata = pc;
                else if (hit_reg)
                    apb_rsp.prdata = host_rdata;
            end
            if (!(hit_ctrl || hit_status || hit_pc || hit_reg || hit_imem))
                apb_rsp.pslverr = 1'b1;         // Unmapped
            else if (apb_req.pwrite && hit_imem && busy)
                apb_rsp.pslverr = 1'b1;         // Program load while running
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_HALTED: if (start_ok) state_nxt = ST_RUN;
            ST_RUN:             if (halt_seen) state_nxt = ST_DRAIN;
            ST_DRAIN:           if (drain_cnt) state_nxt = ST_HALTED;
            default:            state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            drain_cnt <= 1'b0;
        end else begin
            state     <= state_nxt;
            drain_cnt <= (state == ST_DRAIN) && !drain_cnt;   // 0, 1, then leave
        end
    end

    assign run     = state == ST_RUN;
    assign running = state == ST_RUN;
    assign halted  = state == ST_HALTED;

    // Host must open every transfer with a setup phase
    a_penable_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel)
        else $error("penable without psel");

    // Drain lasts two cycles after the HALT is decoded
    a_drain_len: assert property (@(posedge clk) disable iff (rst)
        (state == ST_RUN && halt_seen) |=> state == ST_DRAIN ##1 state == ST_DRAIN
        ##1 state == ST_HALTED)
        else $error("drain length wrong");

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     running,
    output logic     halted
);

    logic                               run, pc_clear, halt_seen;
    pc_t                                pc, next_pc;
    instr_t                             instr;
    logic                               imem_we;
    logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_waddr;
    instr_t                             imem_wdata;
    reg_addr_t                          host_raddr, ra1, ra2;
    word_t                              host_rdata, rd1, rd2;
    dec_exe_t                           dec;
    wb_t                                ex_fwd, wb;

    cpu_run_ctrl u_run_ctrl (
        .clk, .rst, .apb_req, .halt_seen, .pc, .host_rdata,
        .apb_rsp, .run, .pc_clear, .host_raddr,
        .imem_we, .imem_waddr, .imem_wdata,
        .running, .halted
    );

    cpu_pc_counter u_pc (
        .clk, .rst, .run, .pc_clear, .next_pc, .pc
    );

    cpu_imem u_imem (
        .clk,
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (pc),                    // Fetch port
        .rdata (instr)
    );

    cpu_regfile u_regfile (
        .clk, .rst, .ra1, .ra2, .host_raddr, .wb,
        .rd1, .rd2, .host_rdata
    );

    cpu_decode_stage u_decode (
        .clk, .rst, .run, .instr, .pc, .rd1, .rd2, .ex_fwd, .wb,
        .ra1, .ra2, .next_pc, .halt_seen, .dec
    );

    cpu_execute_stage u_execute (
        .clk, .rst, .dec, .ex_fwd, .wb
    );

endmodule

//--- flist.f
+incdir+.
cpu_pkg.sv
cpu_run_ctrl.sv
cpu_pc_counter.sv
cpu_imem.sv
cpu_regfile.sv
cpu_decode_stage.sv
cpu_execute_stage.sv
cpu_top.sv
tb_cpu_top.sv

//--- tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int NUM_PROGRAMS = 6;
    localparam int CYCLE_LIMIT  = NUM_PROGRAMS * (64 * 4 + 100);

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        running;
    logic        halted;

    logic [15:0] lfsr_q;                // Stimulus LFSR state
    logic [15:0] prog [64];             // Program being built
    int          prog_len;
    logic [15:0] image [64];            // Reference copy of the loaded program
    logic [15:0] model_regs [16];
    logic [15:0] model_pc;              // PC of the HALT that ends the run
    int          errors;
    int          checks;
    int          cycles;

    cpu_top dut (
        .clk, .rst, .apb_req, .apb_rsp, .running, .halted
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        errors++;
        $display("FAIL %s got %h expected %h", name, got, exp);
    endtask

    task automatic expect_equal(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic next_rand_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], next_rand_bit()};     // One step per bit
        return v;
    endfunction

    // One APB transfer, setup then access, idle afterwards
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;                                     // Mid low phase, response settled
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic append_instr(input logic [15:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // ISA level interpreter over the image, stops on HALT
    task automatic run_model();
        logic [15:0] ins, a, b, y;
        logic [3:0]  op, r1, r2, fn;
        int          steps;
        int          off;
        model_pc = '0;
        steps    = 0;
        forever begin
            ins = image[model_pc[6:1]];
            op  = ins[15:12];
            r1  = ins[11:8];
            r2  = ins[7:4];
            fn  = ins[3:0];
            a   = model_regs[r1];
            b   = model_regs[r2];
            if (op == 4'hF || steps > 1000)
                break;
            steps++;
            y = 'x;
            case (op)
                4'h0: case (fn)
                    4'h0: y = a + b;
                    4'h1: y = a - b;
                    4'h2: y = a & b;
                    4'h3: y = a | b;
                    4'h4: y = a ^ b;
                    4'h5: y = a << b[3:0];
                    default: y = '0;
                endcase
                4'h1: y = a + {12'h000, fn};    // Immediate zero extended
                default: ;
            endcase
            if ((op == 4'h0 || op == 4'h1) && r1 != 4'h0)
                model_regs[r1] = y;
            off = $signed(fn) * 2;              // Signed offset in bytes
            if ((op == 4'h2 && a == b) || (op == 4'h3 && a != b))
                model_pc = model_pc + 16'(off);
            else
                model_pc = model_pc + 16'd2;
        end
        if (steps > 1000)
            report_failure("reference model never reached HALT");
    endtask

    // Load, start, wait for halted, then compare PC and registers
    task automatic run_program(input logic probe_busy);
        logic [15:0] data;
        logic        err;
        for (int i = 0; i < prog_len; i++) begin
            apb_transfer(1'b1, `CPU_ADDR_IMEM + 12'(4 * i), prog[i], data, err);
            expect_equal("pslverr", {15'b0, err}, 16'h0000);
            image[i] = prog[i];
        end
        run_model();
        apb_transfer(1'b1, `CPU_ADDR_CTRL, 16'h0001, data, err);
        if (probe_busy) begin
            apb_transfer(1'b1, `CPU_ADDR_IMEM + 12'hFC, 16'h0000, data, err);
            expect_equal("pslverr", {15'b0, err}, 16'h0001);     // Load refused in RUN
            apb_transfer(1'b0, `CPU_ADDR_STATUS, 16'h0000, data, err);
            expect_equal("status", data, 16'(ST_RUN));
        end
        while (!halted)
            @(negedge clk);                     // Watchdog bounds this wait
        apb_transfer(1'b0, `CPU_ADDR_STATUS, 16'h0000, data, err);
        expect_equal("status", data, 16'(ST_HALTED));
        apb_transfer(1'b0, `CPU_ADDR_PC, 16'h0000, data, err);
        expect_equal("pc", data, model_pc);
        for (int r = 0; r < 16; r++) begin
            apb_transfer(1'b0, `CPU_ADDR_REG + 12'(4 * r), 16'h0000, data, err);
            expect_equal($sformatf("r%0d", r), data, model_regs[r]);
        end
    endtask

    // ALU and ADDI mix with short dependency distances
    task automatic random_program();
        logic [3:0] rd, rs, fn, prev;
        prog_len = 0;
        prev     = 4'd1;
        for (int k = 0; k < 24; k++) begin
            rd = 4'(rand_bits(3));
            if (next_rand_bit())
                rs = prev;                      // Back to back dependency
            else
                rs = 4'(rand_bits(3));
            fn = 4'(rand_bits(3));
            if (fn > 4'd5)
                fn = fn - 4'd6;
            if (next_rand_bit())
                append_instr({4'h1, rd, 4'h0, 4'(rand_bits(4))});
            else
                append_instr({4'h0, rd, rs, fn});
            prev = rd;
        end
        append_instr(16'hF000);
    endtask

    // Counting loop plus taken and untaken branches
    task automatic branch_program();
        prog_len = 0;
        append_instr(16'h0114);                 // r1 = 0
        append_instr(16'h0224);
        append_instr(16'h0334);
        append_instr(16'h1207);                 // r2 = 7, loop bound
        append_instr(16'h1101);                 // Loop body
        append_instr(16'h1302);
        append_instr(16'h312E);                 // BNE back two words
        append_instr(16'h2122);                 // BEQ taken, skips next
        append_instr(16'h140F);
        append_instr(16'h2132);                 // BEQ not taken
        append_instr(16'h3003);                 // BNE r0, r0 never taken
        append_instr(16'h1509);
        append_instr(16'hF000);
    endtask

    task automatic addi_program();
        prog_len = 0;
        append_instr(16'h0774);                 // r7 = 0
        append_instr(16'h170F);                 // r7 = 15, no sign extension
        append_instr(16'h1005);                 // Write to r0 dropped
        append_instr(16'h0070);
        append_instr(16'h0884);
        append_instr(16'h0800);                 // r8 + r0 right after r0 writes
        append_instr(16'h1801);
        append_instr(16'hF000);
    endtask

    task automatic restart_program();
        prog_len = 0;
        append_instr(16'h0994);
        append_instr(16'h1903);
        append_instr(16'h0A90);                 // r10 += r9
        append_instr(16'hF000);
    endtask

    // HALT decoded in RUN stops the core on the next edge
    a_halt_stops: assert property (@(posedge clk) disable iff (rst)
        (running && dut.halt_seen) |=> !running)
        else report_failure("core kept running after HALT");

    // Two drain cycles, then halted
    a_drain_then_halted: assert property (@(posedge clk) disable iff (rst)
        $fell(running) |-> !halted ##1 !halted ##1 halted)
        else report_failure("halted did not follow the two drain cycles");

    a_status_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(running && halted))
        else report_failure("running and halted both high");

    a_no_wait_states: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else report_failure("pready low in an access phase");

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [15:0] data;
        logic        err;
        apb_req  = '0;
        rst      = 1'b1;
        lfsr_q   = 16'd81;
        errors   = 0;
        checks   = 0;
        prog_len = 0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;                 // Matches register file reset
        for (int i = 0; i < 64; i++)
            image[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // State after reset, unmapped address
        apb_transfer(1'b0, `CPU_ADDR_STATUS, 16'h0000, data, err);
        expect_equal("status", data, 16'(ST_IDLE));
        expect_equal("halted", {15'b0, halted}, 16'h0000);
        apb_transfer(1'b0, 12'h00C, 16'h0000, data, err);
        expect_equal("pslverr", {15'b0, err}, 16'h0001);

        branch_program();
        run_program(1'b1);                      // Also probes a load during RUN

        for (int p = 0; p < 3; p++) begin
            random_program();
            run_program(1'b0);
        end

        addi_program();
        run_program(1'b0);
        apb_transfer(1'b0, `CPU_ADDR_REG, 16'h0000, data, err);
        expect_equal("r0", data, 16'h0000);
        apb_transfer(1'b0, `CPU_ADDR_REG + 12'h01C, 16'h0000, data, err);
        expect_equal("r7", data, 16'h000F);

        // Second start from HALTED fetches the new word 0
        restart_program();
        run_program(1'b0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
